/* design/fix_checksum.sv */
// FIX checksum unit that sums message bytes modulo 256 and checks the sum against the trailer.
`timescale 1ns/1ns

module fix_checksum import fix_proto_pkg::*, fix_field_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic [7:0]         byte_i,
	input  logic               any_byte_i,
	input  logic               field_end_i,
	input  logic               end_of_body_i,
	input  logic [VALUE_W-1:0] value_i,
	input  logic [LEN_W-1:0]   value_len_i,
	output logic               checksum_ok_o,
	output logic               checksum_bad_o
);

	logic [SUM_W-1:0] run_sum; // All bytes of the current message so far.
	logic [SUM_W-1:0] next_sum;
	logic [SUM_W-1:0] field_sum; // Sum through the most recent SOH.
	logic [SUM_W-1:0] body_sum; // Sum through the SOH before that one.
	logic [9:0]       trailer_num; // Three digits give at most 999.
	logic             trailer_digits;
	logic             trailer_match;

	function automatic logic is_digit(input logic [7:0] c);
		return (c >= DIGIT_ZERO) && (c <= DIGIT_NINE);
	endfunction

	function automatic logic [9:0] digit_val(input logic [7:0] c);
		logic [7:0] d;
		d = c - DIGIT_ZERO;
		return {6'd0, d[3:0]};
	endfunction

	assign next_sum = run_sum + byte_i;

	// The trailer value is hundreds in byte 0, tens in byte 1 and units in byte 2.
	assign trailer_digits = (value_len_i == LEN_W'(CHECKSUM_DIGITS)) &&
		is_digit(value_i[7:0]) && is_digit(value_i[15:8]) && is_digit(value_i[23:16]);
	assign trailer_num = digit_val(value_i[7:0]) * 10'd100 +
		digit_val(value_i[15:8]) * 10'd10 + digit_val(value_i[23:16]);
	assign trailer_match = trailer_digits && (trailer_num == 10'(body_sum));

	// The first byte of the next message may arrive together with end_of_body.
	always_ff @(posedge clk) begin
		if (rst) begin
			run_sum <= '0;
		end else if (end_of_body_i) begin
			run_sum <= any_byte_i ? byte_i : '0;
		end else if (any_byte_i) begin
			run_sum <= next_sum;
		end
	end

	// end_of_body lags the trailer SOH by one cycle, so the trailer has already
	// moved into field_sum and body_sum still ends just before "10=".
	always_ff @(posedge clk) begin
		if (rst) begin
			field_sum <= '0;
			body_sum <= '0;
		end else if (field_end_i) begin
			field_sum <= next_sum; // Includes this SOH.
			body_sum <= field_sum;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			checksum_ok_o <= 1'b0;
			checksum_bad_o <= 1'b0;
		end else begin
			checksum_ok_o <= end_of_body_i && trailer_match;
			checksum_bad_o <= end_of_body_i && !trailer_match; // Wrong length or non-digit is bad.
		end
	end

endmodule

/* design/fix_field_extractor.sv */
// FIX field extractor FSM that assembles tag and value and marks header start and body end.
`timescale 1ns/1ns

module fix_field_extractor import fix_proto_pkg::*, fix_field_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic [7:0]         byte_i,
	input  logic               tag_byte_i,
	input  logic               value_byte_i,
	input  logic               tag_end_i,
	input  logic               field_end_i,
	output logic [TAG_W-1:0]   tag_o,
	output logic [VALUE_W-1:0] value_o,
	output logic [LEN_W-1:0]   value_len_o,
	output logic               field_valid_o,
	output logic               start_of_header_o,
	output logic               end_of_body_o
);

	logic [ST_W-1:0]      state;
	logic [TAG_W-1:0]     tag_acc; // Tag under construction, first character in byte 0.
	logic [VALUE_W-1:0]   value_acc; // Value under construction, first character in byte 0.
	logic [TAG_LEN_W-1:0] tag_cnt; // Next free tag byte, saturates at TAG_CHARS.
	logic [LEN_W-1:0]     value_cnt; // Next free value byte, saturates at VALUE_CHARS.
	logic                 field_done;

	// A field only completes once a tag has started.
	// A stray SOH between fields is ignored.
	assign field_done = field_end_i && (state != ST_IDLE);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (tag_byte_i) begin
						state <= ST_IN_TAG;
					end
				end
				ST_IN_TAG: begin
					if (field_end_i) begin
						state <= ST_IDLE; // Field without '=' ends with an empty value.
					end else if (tag_end_i) begin
						state <= ST_WAIT_VALUE;
					end
				end
				ST_WAIT_VALUE: begin
					if (field_end_i) begin
						state <= ST_IDLE;
					end else if (value_byte_i) begin
						state <= ST_IN_VALUE;
					end
				end
				ST_IN_VALUE: begin
					if (field_end_i) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Working storage. The first tag character of a field clears whatever the
	// previous field left in the high bytes.
	always_ff @(posedge clk) begin
		case (state)
			ST_IDLE: begin
				if (tag_byte_i) begin
					tag_acc <= {{(TAG_W - 8){1'b0}}, byte_i};
					tag_cnt <= TAG_LEN_W'(1);
					value_acc <= '0;
					value_cnt <= '0;
				end
			end
			ST_IN_TAG: begin
				if (tag_byte_i && (tag_cnt < TAG_CHARS)) begin
					tag_acc[8 * tag_cnt +: 8] <= byte_i;
					tag_cnt <= tag_cnt + 1'b1;
				end
			end
			ST_WAIT_VALUE, ST_IN_VALUE: begin
				if (value_byte_i && (value_cnt < VALUE_CHARS)) begin
					value_acc[8 * value_cnt +: 8] <= byte_i; // Extra characters are dropped.
					value_cnt <= value_cnt + 1'b1;
				end
			end
			default: begin
			end
		endcase
	end

	// Results hold steady from one field_valid pulse to the next.
	always_ff @(posedge clk) begin
		if (rst) begin
			tag_o <= '0;
			value_o <= '0;
			value_len_o <= '0;
			field_valid_o <= 1'b0;
			start_of_header_o <= 1'b0;
			end_of_body_o <= 1'b0;
		end else begin
			field_valid_o <= field_done;
			start_of_header_o <= field_done && (tag_acc == TAG_BEGIN_STRING);
			end_of_body_o <= field_done && (tag_acc == TAG_CHECKSUM);
			if (field_done) begin
				tag_o <= tag_acc;
				value_o <= value_acc;
				value_len_o <= value_cnt;
			end
		end
	end

endmodule

/* design/fix_field_pkg.sv */
// Field storage widths, length limits and field assembly state codes for the FIX parser.
package fix_field_pkg;

	// Tag storage

	localparam int TAG_CHARS = 4; // Characters after the fourth are dropped.
	localparam int TAG_W = 8 * TAG_CHARS; // One byte per kept character.
	localparam int TAG_LEN_W = 3; // Counts tag characters from 0 to 4.

	// Value storage

	localparam int VALUE_CHARS = 32; // Characters after the 32nd are dropped.
	localparam int VALUE_W = 8 * VALUE_CHARS; // One byte per kept character.
	localparam int LEN_W = 6; // Counts value characters from 0 to 32.

	// Checksum

	localparam int SUM_W = 8; // The FIX checksum is the byte sum modulo 256.

	// Field assembly states

	localparam int ST_W = 2;
	localparam logic [ST_W-1:0] ST_IDLE = 2'd0; // Between fields, waiting for a tag character.
	localparam logic [ST_W-1:0] ST_IN_TAG = 2'd1; // Collecting tag characters.
	localparam logic [ST_W-1:0] ST_WAIT_VALUE = 2'd2; // Seen '=' but no value character yet.
	localparam logic [ST_W-1:0] ST_IN_VALUE = 2'd3; // Collecting value characters.

endpackage

/* design/fix_parser_top.sv */
// FIX parser top level joining the tokenizer, field extractor and checksum unit.
`timescale 1ns/1ns

module fix_parser_top import fix_field_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               in_valid_i,
	input  logic [7:0]         in_byte_i,
	output logic [TAG_W-1:0]   tag_o,
	output logic [VALUE_W-1:0] value_o,
	output logic [LEN_W-1:0]   value_len_o,
	output logic               field_valid_o,
	output logic               start_of_header_o,
	output logic               end_of_body_o,
	output logic               checksum_ok_o,
	output logic               checksum_bad_o
);

	logic [7:0] tok_byte; // Input byte delayed to match the token strobes.
	logic       tag_byte;
	logic       value_byte;
	logic       tag_end;
	logic       field_end;
	logic       any_byte;

	fix_tokenizer u_tokenizer (
		.clk          (clk),
		.rst          (rst),
		.in_valid_i   (in_valid_i),
		.in_byte_i    (in_byte_i),
		.byte_o       (tok_byte),
		.any_byte_o   (any_byte),
		.tag_byte_o   (tag_byte),
		.value_byte_o (value_byte),
		.tag_end_o    (tag_end),
		.field_end_o  (field_end)
	);

	fix_field_extractor u_extractor (
		.clk               (clk),
		.rst               (rst),
		.byte_i            (tok_byte),
		.tag_byte_i        (tag_byte),
		.value_byte_i      (value_byte),
		.tag_end_i         (tag_end),
		.field_end_i       (field_end),
		.tag_o             (tag_o),
		.value_o           (value_o),
		.value_len_o       (value_len_o),
		.field_valid_o     (field_valid_o),
		.start_of_header_o (start_of_header_o),
		.end_of_body_o     (end_of_body_o)
	);

	// The checksum unit reads the trailer straight from the extractor outputs.
	fix_checksum u_checksum (
		.clk            (clk),
		.rst            (rst),
		.byte_i         (tok_byte),
		.any_byte_i     (any_byte),
		.field_end_i    (field_end),
		.end_of_body_i  (end_of_body_o),
		.value_i        (value_o),
		.value_len_i    (value_len_o),
		.checksum_ok_o  (checksum_ok_o),
		.checksum_bad_o (checksum_bad_o)
	);

endmodule

/* design/fix_proto_pkg.sv */
// FIX protocol constants for delimiters, special tag words and ASCII digit conversion.
package fix_proto_pkg;

	// Delimiters

	localparam logic [7:0] SOH_CHAR = 8'h01; // Closes every tag=value field.
	localparam logic [7:0] EQ_CHAR = 8'h3D; // Separates the tag from its value.

	// Digit handling

	localparam logic [7:0] DIGIT_ZERO = 8'h30; // ASCII '0' is subtracted to get a digit value.
	localparam logic [7:0] DIGIT_NINE = 8'h39; // Highest character that still counts as a digit.

	// The trailer carries the sum as exactly three decimal digits.
	localparam int CHECKSUM_DIGITS = 3;

	// Special tags

	// Tag words hold the first character in the low byte.
	// Bytes beyond the last character are zero.
	localparam logic [31:0] TAG_BEGIN_STRING = 32'h0000_0038; // "8" opens the header.
	localparam logic [31:0] TAG_CHECKSUM = 32'h0000_3031; // "10" is the trailer.

endpackage

/* design/fix_tokenizer.sv */
// FIX tokenizer that classifies each input byte as tag byte, value byte, tag end or field end.
`timescale 1ns/1ns

module fix_tokenizer import fix_proto_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       in_valid_i,
	input  logic [7:0] in_byte_i,
	output logic [7:0] byte_o,
	output logic       any_byte_o,
	output logic       tag_byte_o,
	output logic       value_byte_o,
	output logic       tag_end_o,
	output logic       field_end_o
);

	logic in_value; // High once the current field has passed its '='.
	logic is_soh;
	logic is_eq;

	assign is_soh = (in_byte_i == SOH_CHAR);
	assign is_eq = (in_byte_i == EQ_CHAR);

	// Phase tracking. Only the first '=' of a field moves to the value phase,
	// and any SOH starts a new field in the tag phase.
	always_ff @(posedge clk) begin
		if (rst) begin
			in_value <= 1'b0; // A new stream always begins with a tag.
		end else if (in_valid_i) begin
			if (is_soh) begin
				in_value <= 1'b0;
			end else if (is_eq) begin
				in_value <= 1'b1; // A later '=' in the value leaves the phase unchanged.
			end
		end
	end

	// Registered strobes, one cycle behind the input byte.
	always_ff @(posedge clk) begin
		if (rst) begin
			any_byte_o <= 1'b0;
			tag_byte_o <= 1'b0;
			value_byte_o <= 1'b0;
			tag_end_o <= 1'b0;
			field_end_o <= 1'b0;
		end else begin
			any_byte_o <= in_valid_i; // Delimiters count toward the checksum too.
			field_end_o <= in_valid_i && is_soh;
			tag_end_o <= in_valid_i && is_eq && !in_value;
			tag_byte_o <= in_valid_i && !is_soh && !is_eq && !in_value;
			value_byte_o <= in_valid_i && !is_soh && in_value; // '=' inside a value is data.
		end
	end

	// Byte copy that lines up with the strobes above.
	always_ff @(posedge clk) begin
		if (in_valid_i) begin
			byte_o <= in_byte_i;
		end
	end

endmodule

/* project.f */
design/fix_proto_pkg.sv
design/fix_field_pkg.sv
design/fix_tokenizer.sv
design/fix_field_extractor.sv
design/fix_checksum.sv
design/fix_parser_top.sv
tests/fix_parser_tb.sv

/* tests/fix_parser_tb.sv */
// FIX parser testbench that sends random messages and checks fields and checksum verdicts.
`timescale 1ns/1ns

module fix_parser_tb;

	logic         clk;
	logic         rst;
	logic         in_valid_i;
	logic [7:0]   in_byte_i;
	logic [31:0]  tag_o;
	logic [255:0] value_o;
	logic [5:0]   value_len_o;
	logic         field_valid_o;
	logic         start_of_header_o;
	logic         end_of_body_o;
	logic         checksum_ok_o;
	logic         checksum_bad_o;

	logic [7:0]   tx_q[$]; // Bytes waiting to be driven.
	logic [7:0]   tag_buf[$];
	logic [7:0]   val_buf[$];
	logic [31:0]  exp_tag_q[$];
	logic [255:0] exp_val_q[$];
	int           exp_len_q[$];
	bit           exp_sof_q[$];
	bit           exp_eob_q[$];
	bit           exp_ok_q[$]; // One verdict per message, 1 for a correct trailer.
	int           msg_sum;
	int           errors;
	int           test_base;
	int           tests_run;
	int           tests_failed;
	string        cur_test;
	bit           mon_on;
	bit           eob_seen;
	bit           exp_ok;

	fix_parser_top dut0 (
		.clk               (clk),
		.rst               (rst),
		.in_valid_i        (in_valid_i),
		.in_byte_i         (in_byte_i),
		.tag_o             (tag_o),
		.value_o           (value_o),
		.value_len_o       (value_len_o),
		.field_valid_o     (field_valid_o),
		.start_of_header_o (start_of_header_o),
		.end_of_body_o     (end_of_body_o),
		.checksum_ok_o     (checksum_ok_o),
		.checksum_bad_o    (checksum_bad_o)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	task automatic check_val(input string what, input logic [255:0] exp, input logic [255:0] act);
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: %s expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_quiet();
		check_val("field_valid_o", 0, field_valid_o);
		check_val("start_of_header_o", 0, start_of_header_o);
		check_val("end_of_body_o", 0, end_of_body_o);
		check_val("checksum_ok_o", 0, checksum_ok_o);
		check_val("checksum_bad_o", 0, checksum_bad_o);
		check_val("tag_o", 0, tag_o);
		check_val("value_o", 0, value_o);
		check_val("value_len_o", 0, value_len_o);
	endtask

	function automatic bit tag_is(input string s);
		int i;
		if (tag_buf.size() != s.len()) begin
			return 1'b0;
		end
		for (i = 0; i < s.len(); i++) begin
			if (tag_buf[i] != s[i]) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	task automatic load_tag_text(input string s);
		int i;
		tag_buf.delete();
		for (i = 0; i < s.len(); i++) begin
			tag_buf.push_back(s[i]);
		end
	endtask

	task automatic load_value_text(input string s);
		int i;
		val_buf.delete();
		for (i = 0; i < s.len(); i++) begin
			val_buf.push_back(s[i]);
		end
	endtask

	// Appends tag=value<SOH> to the stream and queues what the DUT should report.
	task automatic push_field();
		logic [31:0]  exp_tag;
		logic [255:0] exp_val;
		int           i;
		exp_tag = '0;
		exp_val = '0;
		for (i = 0; i < tag_buf.size(); i++) begin
			if (i < 4) begin
				exp_tag[8 * i +: 8] = tag_buf[i]; // First character in the low byte.
			end
			tx_q.push_back(tag_buf[i]);
			msg_sum += tag_buf[i];
		end
		tx_q.push_back(8'h3D); // The '=' separator.
		msg_sum += 8'h3D;
		for (i = 0; i < val_buf.size(); i++) begin
			if (i < 32) begin
				exp_val[8 * i +: 8] = val_buf[i]; // Characters past 32 are dropped.
			end
			tx_q.push_back(val_buf[i]);
			msg_sum += val_buf[i];
		end
		tx_q.push_back(8'h01); // SOH ends the field.
		msg_sum += 8'h01;
		exp_tag_q.push_back(exp_tag);
		exp_val_q.push_back(exp_val);
		exp_len_q.push_back((val_buf.size() > 32) ? 32 : val_buf.size());
		exp_sof_q.push_back(tag_is("8"));
		exp_eob_q.push_back(tag_is("10"));
	endtask

	task automatic random_body_tag();
		int         n;
		int         i;
		logic [7:0] c;
		do begin
			n = 1 + $urandom % 4;
			tag_buf.delete();
			c = 8'h31 + $urandom % 9; // No leading zero.
			tag_buf.push_back(c);
			for (i = 1; i < n; i++) begin
				c = 8'h30 + $urandom % 10;
				tag_buf.push_back(c);
			end
		end while (tag_is("8") || tag_is("10"));
	endtask

	// Mode 0 gives a correct trailer, 1 a wrong three-digit one, 2 a two-digit one.
	task automatic build_message(input int mode, input int long_len);
		int         n_body;
		int         n_val;
		int         k;
		int         i;
		int         tv;
		logic [7:0] c;
		msg_sum = 0;
		load_tag_text("8");
		load_value_text("FIX.4.4");
		push_field();
		n_body = 1 + $urandom % 6;
		for (k = 0; k < n_body; k++) begin
			random_body_tag();
			n_val = (long_len > 0 && k == 0) ? long_len : 1 + $urandom % 32;
			val_buf.delete();
			for (i = 0; i < n_val; i++) begin
				c = 8'h20 + $urandom % 95; // Printable ASCII from space to '~'.
				val_buf.push_back(c);
			end
			push_field();
		end
		tv = msg_sum % 256; // Everything so far comes before "10=".
		load_tag_text("10");
		val_buf.delete();
		if (mode == 2) begin
			tv = tv % 100;
		end else begin
			if (mode == 1) begin
				tv = (tv + 1 + $urandom % 998) % 1000; // Never equal to the true sum.
			end
			c = 8'h30 + tv / 100;
			val_buf.push_back(c);
		end
		c = 8'h30 + (tv / 10) % 10;
		val_buf.push_back(c);
		c = 8'h30 + tv % 10;
		val_buf.push_back(c);
		push_field();
		exp_ok_q.push_back(mode == 0);
	endtask

	task automatic send_stream(input int max_gap);
		logic [7:0] b;
		int         gap;
		@(posedge clk);
		#10;
		while (tx_q.size() != 0) begin
			b = tx_q.pop_front();
			in_valid_i = 1'b1;
			in_byte_i = b;
			@(posedge clk);
			#10;
			in_valid_i = 1'b0;
			gap = $urandom % (max_gap + 1);
			repeat (gap) begin
				@(posedge clk);
				#10;
			end
		end
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while ((exp_tag_q.size() != 0 || exp_ok_q.size() != 0) && cycles < 200) begin
			@(negedge clk);
			cycles++;
		end
		if (exp_tag_q.size() != 0 || exp_ok_q.size() != 0) begin
			$display("Timeout in %s: expected fields or checksum verdicts never arrived", cur_test);
			$display("Done: errors found");
			$finish;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_base = errors;
	endtask

	task automatic end_test();
		repeat (4) @(negedge clk); // Leaves room for stray pulses to show up.
		tests_run++;
		if (errors == test_base) begin
			$display("Test %s passed", cur_test);
		end else begin
			tests_failed++;
			$display("Test %s failed with %0d errors", cur_test, errors - test_base);
		end
	endtask

	// Outputs are sampled on the falling edge, halfway between updates.
	always @(negedge clk) begin
		if (mon_on) begin
			if (field_valid_o) begin
				if (exp_tag_q.size() == 0) begin
					errors++;
					$display("%s: field_valid_o pulsed when no field was expected", cur_test);
				end else begin
					check_val("tag_o", exp_tag_q.pop_front(), tag_o);
					check_val("value_o", exp_val_q.pop_front(), value_o);
					check_val("value_len_o", exp_len_q.pop_front(), value_len_o);
					check_val("start_of_header_o", exp_sof_q.pop_front(), start_of_header_o);
					check_val("end_of_body_o", exp_eob_q.pop_front(), end_of_body_o);
				end
			end else if (start_of_header_o || end_of_body_o) begin
				errors++;
				$display("%s: header or trailer mark pulsed without field_valid_o", cur_test);
			end
			if (checksum_ok_o || checksum_bad_o) begin
				if (!eob_seen) begin
					errors++;
					$display("%s: checksum pulse did not follow end_of_body_o by one cycle", cur_test);
				end else if (exp_ok_q.size() == 0) begin
					errors++;
					$display("%s: checksum pulse arrived with no message pending", cur_test);
				end else begin
					exp_ok = exp_ok_q.pop_front();
					check_val("checksum_ok_o", exp_ok, checksum_ok_o);
					check_val("checksum_bad_o", !exp_ok, checksum_bad_o);
				end
			end else if (eob_seen) begin
				errors++;
				$display("%s: no checksum pulse one cycle after end_of_body_o", cur_test);
			end
			eob_seen = end_of_body_o;
		end
	end

	initial begin
		int i;
		void'($urandom(44927));
		rst = 1'b1;
		in_valid_i = 1'b0;
		in_byte_i = 8'h00;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		mon_on = 1'b0;
		eob_seen = 1'b0;
		begin_test("reset");
		@(posedge clk);
		repeat (4) begin
			@(negedge clk);
			check_quiet();
		end
		@(posedge clk);
		#10;
		rst = 1'b0; // Released after five rising edges.
		repeat (2) begin
			@(negedge clk);
			check_quiet();
		end
		end_test();
		mon_on = 1'b1;
		begin_test("random_fields");
		for (i = 0; i < 10; i++) begin
			build_message(0, 0);
			send_stream(3);
			wait_drained();
		end
		end_test();
		begin_test("checksum_bad");
		for (i = 0; i < 6; i++) begin
			build_message(1 + i % 2, 0);
			send_stream(3);
			wait_drained();
		end
		end_test();
		begin_test("long_value");
		build_message(0, 40);
		send_stream(2);
		wait_drained();
		build_message(0, 33);
		send_stream(0);
		wait_drained();
		end_test();
		begin_test("back_to_back");
		for (i = 0; i < 6; i++) begin
			build_message(i % 3, 0);
		end
		send_stream(0); // Whole stream without a single idle cycle.
		wait_drained();
		for (i = 0; i < 6; i++) begin
			build_message(0, 0);
		end
		send_stream(3);
		wait_drained();
		end_test();
		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
